// ==== logic/cpuPkg.sv ====
////////////////////
// Shared widths, ISA encodings and pipeline stage payloads
////////////////////
package cpuPkg;

  localparam int wordWidth = 16;  // Data and address width
  localparam int regCount  = 16;

  typedef logic [wordWidth-1:0]        wordT;
  typedef logic [$clog2(regCount)-1:0] regIdxT;

  // Top nibble of the instruction word
  typedef enum logic [3:0] {
    ADD = 4'd0,
    SUB = 4'd1,
    XOR = 4'd2,
    SLL = 4'd4,
    SRA = 4'd5,
    LW  = 4'd8,
    SW  = 4'd9,
    LLB = 4'd10,
    LHB = 4'd11,
    B   = 4'd12,
    BR  = 4'd13,
    PCS = 4'd14,
    HLT = 4'd15
  } opcodeT;

  typedef struct packed {
    logic z;  // Zero
    logic v;  // Signed overflow
    logic n;  // Negative
  } flagsT;

  // Branch condition field, instr[11:9]
  typedef enum logic [2:0] {
    condNe  = 3'd0,
    condEq  = 3'd1,
    condGt  = 3'd2,
    condLt  = 3'd3,
    condGe  = 3'd4,
    condLe  = 3'd5,
    condOv  = 3'd6,
    condAll = 3'd7
  } condT;

  typedef struct packed {
    logic regWrite;
    logic memToReg;   // Writeback takes load data
    logic memWrite;
    logic aluSrc;     // Operand B from immediate
    logic setsFlags;
    logic isBranch;
    logic isHalt;
  } ctrlT;

  ////////////////////
  // Stage payloads

  typedef struct packed {
    logic valid;
    wordT instr;
    wordT pcPlus2;
  } ifIdT;

  typedef struct packed {
    logic   valid;
    ctrlT   ctrl;
    opcodeT opcode;
    condT   cond;
    regIdxT rs;        // Zero when not read
    regIdxT rt;        // Zero when not read
    regIdxT dst;
    wordT   opA;
    wordT   opB;
    wordT   imm;
    wordT   brOffset;  // Sign extended and doubled
    wordT   pcPlus2;
  } idExT;

  typedef struct packed {
    logic   valid;
    logic   regWrite;
    logic   memToReg;
    logic   memWrite;
    regIdxT dst;
    wordT   aluResult;  // Also the data address
    wordT   storeData;
  } exMemT;

  typedef struct packed {
    logic   valid;
    logic   regWrite;
    regIdxT dst;
    wordT   result;
  } memWbT;

  // Register write seen outside the core
  typedef struct packed {
    logic   enable;
    regIdxT regNum;
    wordT   data;
  } wbTraceT;

  // Program word for instruction memory
  typedef struct packed {
    logic enable;
    wordT addr;
    wordT data;
  } memLoadT;

endpackage

// ==== logic/pipelineReg.sv ====
////////////////////
// Stage register with enable and flush
////////////////////
module pipelineReg #(
  parameter type payloadT = logic
) (
  input  logic    clk,
  input  logic    reset,
  input  logic    enable,  // Low holds the stage
  input  logic    flush,   // Inserts a bubble
  input  payloadT d,
  output payloadT q
);

  // Flush beats enable, zero payload drops valid
  always_ff @(posedge clk) begin
    if (reset || flush) begin
      q <= '0;
    end else if (enable) begin
      q <= d;
    end
  end

endmodule

// ==== logic/controlUnit.sv ====
////////////////////
// Instruction decoder
////////////////////
module controlUnit
  import cpuPkg::*;
(
  input  wordT instr,
  output idExT decoded
);

  opcodeT op;

  assign op = opcodeT'(instr[wordWidth-1:12]);

  always_comb begin
    decoded          = '0;  // Operands filled in by the top level
    decoded.opcode   = op;
    decoded.cond     = condT'(instr[11:9]);
    decoded.dst      = instr[11:8];
    decoded.rs       = instr[7:4];
    decoded.rt       = instr[3:0];
    decoded.imm      = {12'b0, instr[3:0]};              // Shift amount or word offset
    decoded.brOffset = {{6{instr[8]}}, instr[8:0], 1'b0};

    // Unread sources go to R0 so they never hazard
    case (op)
      ADD, SUB, XOR: begin
        decoded.ctrl.regWrite  = 1'b1;
        decoded.ctrl.setsFlags = 1'b1;
      end
      SLL, SRA: begin
        decoded.ctrl.regWrite = 1'b1;
        decoded.ctrl.aluSrc   = 1'b1;
        decoded.rt            = '0;
      end
      LW: begin
        decoded.ctrl.regWrite = 1'b1;
        decoded.ctrl.memToReg = 1'b1;
        decoded.ctrl.aluSrc   = 1'b1;
        decoded.rt            = '0;
      end
      SW: begin
        decoded.ctrl.memWrite = 1'b1;
        decoded.ctrl.aluSrc   = 1'b1;
        decoded.rt            = instr[11:8];  // Store data lives in rd slot
        decoded.dst           = '0;
      end
      LLB, LHB: begin
        decoded.ctrl.regWrite = 1'b1;
        decoded.ctrl.aluSrc   = 1'b1;
        decoded.rs            = instr[11:8];  // Keeps the other byte of rd
        decoded.rt            = '0;
        decoded.imm           = {{8{instr[7]}}, instr[7:0]};
      end
      B, BR: begin
        decoded.ctrl.isBranch = 1'b1;
        decoded.rs            = (op == BR) ? instr[7:4] : '0;
        decoded.rt            = '0;
        decoded.dst           = '0;
      end
      PCS: begin
        decoded.ctrl.regWrite = 1'b1;
        decoded.rs            = '0;
        decoded.rt            = '0;
      end
      HLT: begin
        decoded.ctrl.isHalt = 1'b1;
        decoded.rs          = '0;
        decoded.rt          = '0;
        decoded.dst         = '0;
      end
      default: begin  // Unused opcodes, no effect
        decoded.rs  = '0;
        decoded.rt  = '0;
        decoded.dst = '0;
      end
    endcase
  end

endmodule

// ==== logic/registerFile.sv ====
////////////////////
// Register file, R0 hardwired to zero
////////////////////
module registerFile
  import cpuPkg::*;
(
  input  logic   clk,
  input  logic   reset,
  input  regIdxT srcReg1,
  input  regIdxT srcReg2,
  input  logic   writeEnable,
  input  regIdxT dstReg,
  input  wordT   dstData,
  output wordT   srcData1,
  output wordT   srcData2
);

  wordT regs [regCount];

  // Same cycle write shows through to the read
  function automatic wordT readPort(regIdxT src, wordT stored, logic we,
                                    regIdxT dst, wordT data);
    if (src == '0) return '0;
    if (we && (dst == src)) return data;
    return stored;
  endfunction

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < regCount; i++) begin
        regs[i] <= '0;
      end
    end else if (writeEnable && (dstReg != '0)) begin
      regs[dstReg] <= dstData;
    end
  end

  assign srcData1 = readPort(srcReg1, regs[srcReg1], writeEnable, dstReg, dstData);
  assign srcData2 = readPort(srcReg2, regs[srcReg2], writeEnable, dstReg, dstData);

endmodule

// ==== logic/aluCompute.sv ====
////////////////////
// ALU, flag register and branch condition check
////////////////////
module aluCompute
  import cpuPkg::*;
(
  input  logic   clk,
  input  logic   reset,
  input  logic   valid,
  input  opcodeT opcode,
  input  condT   cond,
  input  wordT   operandA,
  input  wordT   operandB,
  output wordT   result,
  output logic   branchTaken
);

  localparam int msb = wordWidth - 1;

  flagsT flags;
  logic  overflow;
  logic  condHolds;

  always_comb begin
    case (opcode)
      ADD:     result = operandA + operandB;  // Wraps
      SUB:     result = operandA - operandB;
      XOR:     result = operandA ^ operandB;
      SLL:     result = operandA << operandB[3:0];
      SRA:     result = wordT'($signed(operandA) >>> operandB[3:0]);
      LW, SW:  result = operandA + (operandB << 1);  // Offset counts words
      LLB:     result = {operandA[msb:8], operandB[7:0]};
      LHB:     result = {operandB[7:0], operandA[7:0]};
      PCS:     result = operandA;                    // pcPlus2 muxed in upstream
      default: result = '0;
    endcase
  end

  // Sign of result disagrees with like-signed inputs
  always_comb begin
    if (opcode == SUB) begin
      overflow = (operandA[msb] != operandB[msb]) && (result[msb] != operandA[msb]);
    end else begin
      overflow = (operandA[msb] == operandB[msb]) && (result[msb] != operandA[msb]);
    end
  end

  ////////////////////
  // Flags

  always_ff @(posedge clk) begin
    if (reset) begin
      flags <= '0;
    end else if (valid) begin
      case (opcode)
        ADD, SUB: flags <= '{z: (result == '0), v: overflow, n: result[msb]};
        XOR:      flags.z <= (result == '0);  // V and N kept
        default:  ;
      endcase
    end
  end

  always_comb begin
    case (cond)
      condNe:  condHolds = ~flags.z;
      condEq:  condHolds = flags.z;
      condGt:  condHolds = ~flags.z & ~flags.n;
      condLt:  condHolds = flags.n;
      condGe:  condHolds = flags.z | ~flags.n;
      condLe:  condHolds = flags.z | flags.n;
      condOv:  condHolds = flags.v;
      default: condHolds = 1'b1;  // Always
    endcase
  end

  assign branchTaken = valid & ((opcode == B) | (opcode == BR)) & condHolds;

endmodule

// ==== logic/hazard.sv ====
////////////////////
// Forwarding selects, load-use stall, branch flush
////////////////////
module hazard
  import cpuPkg::*;
(
  input  regIdxT     idRs,
  input  regIdxT     idRt,
  input  ctrlT       exCtrl,       // Already cleared for bubbles
  input  regIdxT     exRs,
  input  regIdxT     exRt,
  input  regIdxT     exDst,
  input  logic       memRegWrite,
  input  regIdxT     memDst,
  input  logic       wbRegWrite,
  input  regIdxT     wbDst,
  input  logic       branchTaken,
  output logic [1:0] forwardA,     // 01 memory, 10 writeback, 00 register file
  output logic [1:0] forwardB,
  output logic       stall,
  output logic       flushDecode,
  output logic       flushExecute
);

  logic loadUse;

  // Younger producer wins, R0 never forwarded
  function automatic logic [1:0] pickSource(regIdxT src, logic memWe, regIdxT memRd,
                                            logic wbWe, regIdxT wbRd);
    if (src == '0) return 2'b00;
    if (memWe && (memRd == src)) return 2'b01;
    if (wbWe && (wbRd == src)) return 2'b10;
    return 2'b00;
  endfunction

  assign forwardA = pickSource(exRs, memRegWrite, memDst, wbRegWrite, wbDst);
  assign forwardB = pickSource(exRt, memRegWrite, memDst, wbRegWrite, wbDst);

  // Load result arrives too late for the next instruction
  assign loadUse = exCtrl.memToReg & exCtrl.regWrite & (exDst != '0) &
                   ((exDst == idRs) | (exDst == idRt));

  assign stall        = loadUse;
  assign flushDecode  = branchTaken;            // Squash fetched word
  assign flushExecute = branchTaken | loadUse;  // Squash decode, or bubble

endmodule

// ==== logic/memory.sv ====
////////////////////
// Instruction and data memory, single cycle
////////////////////
module memory
  import cpuPkg::*;
#(
  parameter int words = 256  // Per array
) (
  input  logic    clk,
  input  memLoadT progLoad,
  input  wordT    instrAddr,
  output wordT    instr,
  input  wordT    dataAddr,
  input  logic    dataWrite,
  input  wordT    storeData,
  output wordT    loadData
);

  localparam int idxBits = $clog2(words);

  wordT instrMem [words];
  wordT dataMem  [words];

  // Byte addresses, bit 0 ignored
  assign instr    = instrMem[instrAddr[idxBits:1]];
  assign loadData = dataMem[dataAddr[idxBits:1]];

  always_ff @(posedge clk) begin
    if (progLoad.enable) instrMem[progLoad.addr[idxBits:1]] <= progLoad.data;
  end

  always_ff @(posedge clk) begin
    if (dataWrite) dataMem[dataAddr[idxBits:1]] <= storeData;
  end

endmodule

// ==== logic/cpu.sv ====
////////////////////
// Five stage pipelined CPU top level
// PC, stage wiring, forwarding muxes, halt tracking
////////////////////
module cpu
  import cpuPkg::*;
#(
  parameter int memWords = 256  // Words in each memory array
) (
  input  logic    clk,
  input  logic    reset,
  input  memLoadT progLoad,
  output logic    hlt,
  output wordT    pcOut,
  output wbTraceT wbTrace
);

  wordT       pc;
  wordT       pcPlus2;
  wordT       pcNext;
  wordT       instrF;
  ifIdT       ifIdD, ifIdQ;
  idExT       decoded, idExD, idExQ;
  exMemT      exMemD, exMemQ;
  memWbT      memWbD, memWbQ;
  ctrlT       exCtrl;
  wordT       srcData1, srcData2;
  wordT       fwdA, fwdB;
  wordT       aluA, aluB, aluResult, brTarget;
  wordT       loadData, memResult;
  logic [1:0] forwardA, forwardB;
  logic       stall, flushDecode, flushExecute, branchTaken;
  logic       haltDecode, haltMem, freeze;

  ////////////////////
  // Fetch

  assign pcPlus2    = pc + wordT'(2);
  assign haltDecode = ifIdQ.valid & decoded.ctrl.isHalt & ~branchTaken;  // Squashed HLT ignored
  assign freeze     = haltDecode | exCtrl.isHalt | haltMem | hlt;       // HLT in flight

  always_comb begin
    if (branchTaken) pcNext = brTarget;
    else if (stall || freeze) pcNext = pc;
    else pcNext = pcPlus2;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pc      <= '0;
      haltMem <= 1'b0;
      hlt     <= 1'b0;
    end else begin
      pc      <= pcNext;
      haltMem <= exCtrl.isHalt;
      hlt     <= hlt | haltMem;  // Rises with HLT in writeback, sticky
    end
  end

  assign ifIdD = '{valid: ~freeze, instr: instrF, pcPlus2: pcPlus2};

  pipelineReg #(.payloadT(ifIdT)) ifIdReg (
    .clk, .reset, .enable(~stall), .flush(flushDecode), .d(ifIdD), .q(ifIdQ)
  );

  ////////////////////
  // Decode

  controlUnit decoder (.instr(ifIdQ.instr), .decoded(decoded));

  registerFile regs (
    .clk, .reset,
    .srcReg1(decoded.rs), .srcReg2(decoded.rt),
    .writeEnable(memWbQ.regWrite), .dstReg(memWbQ.dst), .dstData(memWbQ.result),
    .srcData1, .srcData2
  );

  always_comb begin
    idExD         = decoded;
    idExD.valid   = ifIdQ.valid;
    idExD.opA     = srcData1;
    idExD.opB     = srcData2;
    idExD.pcPlus2 = ifIdQ.pcPlus2;
  end

  pipelineReg #(.payloadT(idExT)) idExReg (
    .clk, .reset, .enable(1'b1), .flush(flushExecute), .d(idExD), .q(idExQ)
  );

  ////////////////////
  // Execute

  assign exCtrl = idExQ.valid ? idExQ.ctrl : '0;  // Bubbles carry no control

  hazard hazardUnit (
    .idRs(decoded.rs), .idRt(decoded.rt),
    .exCtrl, .exRs(idExQ.rs), .exRt(idExQ.rt), .exDst(idExQ.dst),
    .memRegWrite(exMemQ.regWrite), .memDst(exMemQ.dst),
    .wbRegWrite(memWbQ.regWrite), .wbDst(memWbQ.dst),
    .branchTaken, .forwardA, .forwardB, .stall, .flushDecode, .flushExecute
  );

  always_comb begin
    case (forwardA)
      2'b01:   fwdA = memResult;
      2'b10:   fwdA = memWbQ.result;
      default: fwdA = idExQ.opA;
    endcase
    case (forwardB)
      2'b01:   fwdB = memResult;
      2'b10:   fwdB = memWbQ.result;
      default: fwdB = idExQ.opB;
    endcase
  end

  assign aluA = (idExQ.opcode == PCS) ? idExQ.pcPlus2 : fwdA;
  assign aluB = exCtrl.aluSrc ? idExQ.imm : fwdB;

  aluCompute alu (
    .clk, .reset, .valid(idExQ.valid), .opcode(idExQ.opcode), .cond(idExQ.cond),
    .operandA(aluA), .operandB(aluB), .result(aluResult), .branchTaken
  );

  // BR jumps to rs, B is PC relative
  assign brTarget = (idExQ.opcode == BR) ? fwdA : idExQ.pcPlus2 + idExQ.brOffset;

  assign exMemD = '{valid: idExQ.valid, regWrite: exCtrl.regWrite,
                    memToReg: exCtrl.memToReg, memWrite: exCtrl.memWrite,
                    dst: idExQ.dst, aluResult: aluResult, storeData: fwdB};

  pipelineReg #(.payloadT(exMemT)) exMemReg (
    .clk, .reset, .enable(1'b1), .flush(1'b0), .d(exMemD), .q(exMemQ)
  );

  ////////////////////
  // Memory

  memory #(.words(memWords)) mem (
    .clk, .progLoad, .instrAddr(pc), .instr(instrF),
    .dataAddr(exMemQ.aluResult), .dataWrite(exMemQ.memWrite),
    .storeData(exMemQ.storeData), .loadData
  );

  assign memResult = exMemQ.memToReg ? loadData : exMemQ.aluResult;

  assign memWbD = '{valid: exMemQ.valid, regWrite: exMemQ.regWrite,
                    dst: exMemQ.dst, result: memResult};

  pipelineReg #(.payloadT(memWbT)) memWbReg (
    .clk, .reset, .enable(1'b1), .flush(1'b0), .d(memWbD), .q(memWbQ)
  );

  ////////////////////
  // Writeback

  assign wbTrace = '{enable: memWbQ.valid & memWbQ.regWrite,
                     regNum: memWbQ.dst, data: memWbQ.result};
  assign pcOut   = pc;

endmodule

// ==== bench/cpuTb.sv ====
////////////////////
// Testbench for the pipelined CPU
// Program load, writeback trace checks, watchdog
////////////////////
module cpuTb
  import cpuPkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  logic    clk;
  logic    reset;
  memLoadT progLoad;
  logic    hlt;
  wordT    pcOut;
  wbTraceT wbTrace;

  logic [15:0] testData [256];  // Raw words of the data file
  logic [7:0]  readPtr;         // Next word to parse
  wordT        progWords [$];
  wordT        expReg [$];      // Expected trace, in program order
  wordT        expData [$];
  wordT        finalPc;
  int          progCount = 0;
  int          expCount = 0;
  int          seen = 0;        // Writebacks observed so far
  int          valueErrors = 0;
  int          otherErrors = 0;
  logic        loaded;

  cpu #(.memWords(256)) uut (
    .clk, .reset, .progLoad, .hlt, .pcOut, .wbTrace
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;  // 4 ns period
  end

  ////////////////////
  // Helpers

  task automatic compareValue(input string name, input wordT actual, input wordT expected);
    if (actual !== expected) begin
      $display("ERR t=%0t %s actual %h expected %h", $time, name, actual, expected);
      valueErrors++;
    end
  endtask

  task automatic nextWord(output wordT value);
    value   = testData[readPtr];
    readPtr = readPtr + 8'd1;
  endtask

  // Program, then trace pairs, then final PC
  task automatic readTestData();
    wordT value;
    wordT regNum;
    $readmemh("bench/testdata.txt", testData);
    readPtr = '0;
    nextWord(value);
    progCount = int'(value);
    for (int i = 0; i < progCount; i++) begin
      nextWord(value);
      progWords.push_back(value);
    end
    nextWord(value);
    expCount = int'(value);
    for (int i = 0; i < expCount; i++) begin
      nextWord(regNum);
      nextWord(value);
      expReg.push_back(regNum);
      expData.push_back(value);
    end
    nextWord(finalPc);
  endtask

  // One word per cycle, byte addresses
  task automatic loadProgram();
    for (int i = 0; i < progCount; i++) begin
      @(posedge clk);
      #1;
      progLoad = '{enable: 1'b1, addr: wordT'(2 * i), data: progWords[i]};
    end
    @(posedge clk);
    #1;
    progLoad = '0;
  endtask

  task automatic checkTrace();
    if (wbTrace.enable) begin
      if (seen < expCount) begin
        compareValue("wbTrace.regNum", {12'b0, wbTrace.regNum}, expReg[seen]);
        compareValue("wbTrace.data", wbTrace.data, expData[seen]);
      end else begin
        $display("Unexpected extra writeback to R%0d with %h at t=%0t",
                 wbTrace.regNum, wbTrace.data, $time);
        otherErrors++;
      end
      seen++;
    end
  endtask

  ////////////////////
  // Main sequence

  initial begin
    reset    = 1'b1;
    progLoad = '0;
    loaded   = 1'b0;
    readTestData();
    if (progCount == 0 || expCount == 0) begin
      $display("Data file gave no program or no expected writebacks");
      otherErrors++;
    end
    loaded = 1'b1;
    loadProgram();  // Reset stays high through the load
    repeat (3) @(posedge clk);
    #1;
    reset = 1'b0;
    compareValue("hlt", {15'b0, hlt}, '0);
    compareValue("wbTrace.enable", {15'b0, wbTrace.enable}, '0);
    compareValue("pcOut", pcOut, '0);

    // Trace sampled mid cycle
    while (hlt !== 1'b1) begin
      @(negedge clk);
      checkTrace();
    end
    repeat (8) begin  // Nothing may write back after halt
      @(negedge clk);
      checkTrace();
    end

    if (seen < expCount) begin
      $display("Missing writebacks, saw %0d of %0d", seen, expCount);
      otherErrors++;
    end
    compareValue("pcOut", pcOut, finalPc);
    compareValue("hlt", {15'b0, hlt}, 16'h0001);  // Sticky

    $display("Result: %0d value errors, %0d other errors", valueErrors, otherErrors);
    if (valueErrors + otherErrors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  // Budget grows with program length
  initial begin
    wait (loaded === 1'b1);
    repeat (20 * progCount + 100) @(posedge clk);
    $display("Timeout, halt never reached within %0d cycles", 20 * progCount + 100);
    $display("=== FAIL ===");
    $finish;
  end

endmodule

// ==== bench/testdata.txt ====
// Program word count, program words, writeback count,
// then register/value pairs in trace order, then the final PC
0020
A134 B112 A2FF B280  // 00 constants built by LLB/LHB
0312 1431 2542 4614  // 08 ADD, SUB, XOR, SLL
5723 0011 0806 1967  // 10 SRA, write to R0, read R0, SUB
0A89 9A02 8B02 0CB1  // 18 ADD, SW, LW, load-use ADD
1DCC C002 AE55 C202  // 20 SUB to zero, B NE falls through, B EQ taken
F000 AE66 EF00 A53A  // 28 squashed HLT and LLB, PCS, BR target
DE50 A677 A678 F000  // 30 BR always, shadow words
A679 04F5 F000 A199  // 38 skipped, ADD, final HLT, word after HLT
0014
1 0034  1 1234  2 00FF  2 80FF
3 9333  4 80FF  5 0000  6 2340
7 F01F  0 2468  8 2340  9 3321
A 5661  B 5661  C 6895  D 0000
E 0055  F 002E  5 003A  4 0068
003E

// ==== list.f ====
logic/cpuPkg.sv
logic/pipelineReg.sv
logic/controlUnit.sv
logic/registerFile.sv
logic/aluCompute.sv
logic/hazard.sv
logic/memory.sv
logic/cpu.sv
bench/cpuTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the CPU testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --timescale 1ns/100ps -f list.f --top-module cpuTb \
  -o cpuTb --Mdir obj_dir
./obj_dir/cpuTb > sim.log 2>&1
cat sim.log
if grep -q "=== FAIL ===" sim.log; then
  echo "Simulation failed"
  exit 1
fi
echo "Simulation passed"
